// ==== Makefile ====
TOP = aesDecryptTb

.PHONY: sim clean

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/aesDecryptTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_params.svh"

module aesDecryptTb import aesInvPkg::*;
();
    localparam int CLK_PERIOD = 100;
    localparam int ACK_LIMIT  = 20;

    localparam int SCHED_NONE = 0;
    localparam int SCHED_A1   = 1;
    localparam int SCHED_C1   = 2;

    // --------------------
    // published round keys in round order
    localparam aesBlock_t KEYS_A1 [`AES_NR + 1] = '{
        128'h2b7e151628aed2a6abf7158809cf4f3c,
        128'ha0fafe1788542cb123a339392a6c7605,
        128'hf2c295f27a96b9435935807a7359f67f,
        128'h3d80477d4716fe3e1e237e446d7a883b,
        128'hef44a541a8525b7fb671253bdb0bad00,
        128'hd4d1c6f87c839d87caf2b8bc11f915bc,
        128'h6d88a37a110b3efddbf98641ca0093fd,
        128'h4e54f70e5f5fc9f384a64fb24ea6dc4f,
        128'head27321b58dbad2312bf5607f8d292f,
        128'hac7766f319fadc2128d12941575c006e,
        128'hd014f9a8c9ee2589e13f0cc8b6630ca6
    };

    localparam aesBlock_t KEYS_C1 [`AES_NR + 1] = '{
        128'h000102030405060708090a0b0c0d0e0f,
        128'hd6aa74fdd2af72fadaa678f1d6ab76fe,
        128'hb692cf0b643dbdf1be9bc5006830b3fe,
        128'hb6ff744ed2c2c9bf6c590cbf0469bf41,
        128'h47f7f7bc95353e03f96c32bcfd058dfd,
        128'h3caaa3e8a99f9deb50f3af57adf622aa,
        128'h5e390f7df7a69296a7553dc10aa31f6b,
        128'h14f9701ae35fe28c440adf4d4ea9c026,
        128'h47438735a41c65b9e016baf4aebf7ad2,
        128'h549932d1f08557681093ed9cbe2c974e,
        128'h13111d7fe3944a17f307a78b4d2b30c5
    };

    // --------------------
    // vector table
    localparam int NUM_TESTS = 4;

    string testName [NUM_TESTS] = '{"appB", "appC1", "reloadAppB", "keptAppB"};

    localparam int SCHED_TAB [NUM_TESTS] = '{SCHED_A1, SCHED_C1, SCHED_A1, SCHED_NONE};

    localparam aesBlock_t CIPHER_TAB [NUM_TESTS] = '{
        128'h3925841d02dc09fbdc118597196a0b32,
        128'h69c4e0d86a7b0430d8cdb78070b4c55a,
        128'h3925841d02dc09fbdc118597196a0b32,
        128'h3925841d02dc09fbdc118597196a0b32
    };

    localparam aesBlock_t PLAIN_TAB [NUM_TESTS] = '{
        128'h3243f6a8885a308d313198a2e0370734,
        128'h00112233445566778899aabbccddeeff,
        128'h3243f6a8885a308d313198a2e0370734,
        128'h3243f6a8885a308d313198a2e0370734
    };

    localparam logic HOLD_TAB [NUM_TESTS] = '{1'b0, 1'b1, 1'b1, 1'b1};

    // each entry covers key writes, latency, max hold and handshake
    localparam int WATCHDOG_NS =
        (NUM_TESTS * (11 + `AES_NR + 7 + 4) + 20) * CLK_PERIOD * 2;

    logic      clk;
    logic      arstN;
    logic      keyWe;
    keyIdx_t   keyIdx;
    aesBlock_t keyData;
    logic      req;
    aesBlock_t cipherText;
    logic      ack;
    aesBlock_t plainText;

    integer seed = 32'h0b3e31b3;
    int     errCount = 0;     // value mismatches
    int     failCount = 0;    // protocol failures

    aesDecrypt aesDecrypt_inst
    (
        .clk        (clk),
        .arstN      (arstN),
        .keyWe      (keyWe),
        .keyIdx     (keyIdx),
        .keyData    (keyData),
        .req        (req),
        .cipherText (cipherText),
        .ack        (ack),
        .plainText  (plainText)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------
    // compare tasks
    task automatic checkBlock(input string name, input aesBlock_t expected, input aesBlock_t actual);
        if (actual !== expected)
        begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            errCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("mismatch %s: expected %b, actual %b", name, expected, actual);
            errCount++;
        end
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
            errCount++;
        end
    endtask

    task automatic loadSchedule(input int sel);
        for (int i = 0; i <= `AES_NR; i++)
        begin
            @(negedge clk);
            keyWe   = 1'b1;
            keyIdx  = keyIdx_t'(i);
            keyData = (sel == SCHED_A1) ? KEYS_A1[i] : KEYS_C1[i];
        end
        @(negedge clk);
        keyWe = 1'b0;
    endtask

    // one four-phase decrypt with latency and hold checks
    task automatic runVector(input int t);
        int   latency;
        int   holdCycles;
        int   dropWait;
        logic ackSeen;
        latency  = 0;
        dropWait = 0;
        ackSeen  = 1'b0;
        @(negedge clk);
        cipherText = CIPHER_TAB[t];
        req        = 1'b1;
        @(posedge clk);    // edge E
        while (!ackSeen && latency <= ACK_LIMIT)
        begin
            @(negedge clk);
            if (ack === 1'b1)
                ackSeen = 1'b1;
            else
            begin
                @(posedge clk);
                latency++;
            end
        end
        if (!ackSeen)
        begin
            $display("%s: ack never rose within %0d cycles of req", testName[t], ACK_LIMIT);
            failCount++;
            @(negedge clk);
            req = 1'b0;
        end
        else
        begin
            checkCount({testName[t], " latency"}, `AES_NR, latency);
            checkBlock(testName[t], PLAIN_TAB[t], plainText);
            holdCycles = HOLD_TAB[t] ? int'($unsigned($random(seed)) % 8) : 0;
            repeat (holdCycles)
            begin
                @(negedge clk);
                checkBit({testName[t], " hold ack"}, 1'b1, ack);
                checkBlock({testName[t], " hold"}, PLAIN_TAB[t], plainText);
            end
            req = 1'b0;
            while (ack === 1'b1 && dropWait < 2)
            begin
                @(negedge clk);
                dropWait++;
            end
            checkBit({testName[t], " ack drop"}, 1'b0, ack);
        end
    endtask

    // --------------------
    // main sequence
    initial
    begin
        arstN      = 1'b0;
        keyWe      = 1'b0;
        keyIdx     = '0;
        keyData    = '0;
        req        = 1'b0;
        cipherText = '0;
        repeat (5) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        checkBit("reset ack", 1'b0, ack);
        checkBlock("reset state", '0, plainText);

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            if (SCHED_TAB[t] != SCHED_NONE)
                loadSchedule(SCHED_TAB[t]);
            runVector(t);
        end

        repeat (2) @(negedge clk);
        $display("%0d mismatches, %0d other errors", errCount, failCount);
        if (errCount == 0 && failCount == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/aesDecrypt.sv ====
`timescale 1ns/1ps
`default_nettype none

module aesDecrypt import aesInvPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    // key schedule load
    input  logic      keyWe,
    input  keyIdx_t   keyIdx,
    input  aesBlock_t keyData,
    // four-phase decrypt handshake
    input  logic      req,
    input  aesBlock_t cipherText,
    output logic      ack,
    output aesBlock_t plainText
);
    keyIdx_t   rdIdx;
    aesBlock_t rdKey;

    invRoundIf invRoundIf_inst ();

    roundKeyStore roundKeyStore_inst
    (
        .clk     (clk),
        .arstN   (arstN),
        .keyWe   (keyWe),
        .keyIdx  (keyIdx),
        .keyData (keyData),
        .rdIdx   (rdIdx),
        .rdKey   (rdKey)
    );

    invCipherCtrl invCipherCtrl_inst
    (
        .clk        (clk),
        .arstN      (arstN),
        .req        (req),
        .cipherText (cipherText),
        .ack        (ack),
        .plainText  (plainText),
        .rdIdx      (rdIdx),
        .rdKey      (rdKey),
        .round      (invRoundIf_inst.ctrl)
    );

    // one round per clock
    invRoundUnit invRoundUnit_inst
    (
        .round (invRoundIf_inst.unit)
    );

endmodule

`default_nettype wire

// ==== design/aesInvPkg.sv ====
`default_nettype none

`include "aes_params.svh"

package aesInvPkg;

    typedef logic [`AES_BYTE_BITS-1:0]    aesByte_t;
    typedef logic [`AES_WORD_BITS-1:0]    aesWord_t;
    typedef logic [`AES_BLOCK_BITS-1:0]   aesBlock_t;
    typedef logic [`AES_KEY_IDX_BITS-1:0] keyIdx_t;

    typedef enum logic [1:0]
    {
        IDLE,
        ROUND,
        DONE
    } ctrlState_t;

    // --------------------
    // inverse s-box, indexed by input byte
    localparam aesByte_t INV_SBOX [2**`AES_BYTE_BITS] = '{
        8'h52, 8'h09, 8'h6a, 8'hd5, 8'h30, 8'h36, 8'ha5, 8'h38, 8'hbf, 8'h40, 8'ha3, 8'h9e, 8'h81, 8'hf3, 8'hd7, 8'hfb,
        8'h7c, 8'he3, 8'h39, 8'h82, 8'h9b, 8'h2f, 8'hff, 8'h87, 8'h34, 8'h8e, 8'h43, 8'h44, 8'hc4, 8'hde, 8'he9, 8'hcb,
        8'h54, 8'h7b, 8'h94, 8'h32, 8'ha6, 8'hc2, 8'h23, 8'h3d, 8'hee, 8'h4c, 8'h95, 8'h0b, 8'h42, 8'hfa, 8'hc3, 8'h4e,
        8'h08, 8'h2e, 8'ha1, 8'h66, 8'h28, 8'hd9, 8'h24, 8'hb2, 8'h76, 8'h5b, 8'ha2, 8'h49, 8'h6d, 8'h8b, 8'hd1, 8'h25,
        8'h72, 8'hf8, 8'hf6, 8'h64, 8'h86, 8'h68, 8'h98, 8'h16, 8'hd4, 8'ha4, 8'h5c, 8'hcc, 8'h5d, 8'h65, 8'hb6, 8'h92,
        8'h6c, 8'h70, 8'h48, 8'h50, 8'hfd, 8'hed, 8'hb9, 8'hda, 8'h5e, 8'h15, 8'h46, 8'h57, 8'ha7, 8'h8d, 8'h9d, 8'h84,
        8'h90, 8'hd8, 8'hab, 8'h00, 8'h8c, 8'hbc, 8'hd3, 8'h0a, 8'hf7, 8'he4, 8'h58, 8'h05, 8'hb8, 8'hb3, 8'h45, 8'h06,
        8'hd0, 8'h2c, 8'h1e, 8'h8f, 8'hca, 8'h3f, 8'h0f, 8'h02, 8'hc1, 8'haf, 8'hbd, 8'h03, 8'h01, 8'h13, 8'h8a, 8'h6b,
        8'h3a, 8'h91, 8'h11, 8'h41, 8'h4f, 8'h67, 8'hdc, 8'hea, 8'h97, 8'hf2, 8'hcf, 8'hce, 8'hf0, 8'hb4, 8'he6, 8'h73,
        8'h96, 8'hac, 8'h74, 8'h22, 8'he7, 8'had, 8'h35, 8'h85, 8'he2, 8'hf9, 8'h37, 8'he8, 8'h1c, 8'h75, 8'hdf, 8'h6e,
        8'h47, 8'hf1, 8'h1a, 8'h71, 8'h1d, 8'h29, 8'hc5, 8'h89, 8'h6f, 8'hb7, 8'h62, 8'h0e, 8'haa, 8'h18, 8'hbe, 8'h1b,
        8'hfc, 8'h56, 8'h3e, 8'h4b, 8'hc6, 8'hd2, 8'h79, 8'h20, 8'h9a, 8'hdb, 8'hc0, 8'hfe, 8'h78, 8'hcd, 8'h5a, 8'hf4,
        8'h1f, 8'hdd, 8'ha8, 8'h33, 8'h88, 8'h07, 8'hc7, 8'h31, 8'hb1, 8'h12, 8'h10, 8'h59, 8'h27, 8'h80, 8'hec, 8'h5f,
        8'h60, 8'h51, 8'h7f, 8'ha9, 8'h19, 8'hb5, 8'h4a, 8'h0d, 8'h2d, 8'he5, 8'h7a, 8'h9f, 8'h93, 8'hc9, 8'h9c, 8'hef,
        8'ha0, 8'he0, 8'h3b, 8'h4d, 8'hae, 8'h2a, 8'hf5, 8'hb0, 8'hc8, 8'heb, 8'hbb, 8'h3c, 8'h83, 8'h53, 8'h99, 8'h61,
        8'h17, 8'h2b, 8'h04, 8'h7e, 8'hba, 8'h77, 8'hd6, 8'h26, 8'he1, 8'h69, 8'h14, 8'h63, 8'h55, 8'h21, 8'h0c, 8'h7d
    };

    function automatic aesByte_t invSubByte(input aesByte_t inByte);
        return INV_SBOX[inByte];
    endfunction

    // --------------------
    // gf(2^8) product, poly x^8+x^4+x^3+x+1
    function automatic aesByte_t gfMul(input aesByte_t a, input aesByte_t b);
        aesByte_t acc;
        aesByte_t shifted;
        acc     = '0;
        shifted = a;
        for (int i = 0; i < `AES_BYTE_BITS; i++)
        begin
            if (b[i])
                acc = acc ^ shifted;
            // xtime, fold the carry back in
            shifted = {shifted[`AES_BYTE_BITS-2:0], 1'b0} ^ (shifted[`AES_BYTE_BITS-1] ? 8'h1b : 8'h00);
        end
        return acc;
    endfunction

endpackage

`default_nettype wire

// ==== design/aes_params.svh ====
`ifndef AES_PARAMS_SVH
`define AES_PARAMS_SVH

// --------------------
// block geometry

// columns per block
`define AES_NB 4

// aes-128 only
`define AES_NR 10

`define AES_BYTE_BITS 8
`define AES_WORD_BITS 32
`define AES_BLOCK_BITS 128

// --------------------
// round key index, 0 to AES_NR
`define AES_KEY_IDX_BITS 4

`endif

// ==== design/invCipherCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_params.svh"

module invCipherCtrl import aesInvPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      req,
    input  aesBlock_t cipherText,
    output logic      ack,
    output aesBlock_t plainText,
    output keyIdx_t   rdIdx,
    input  aesBlock_t rdKey,
    invRoundIf.ctrl   round
);
    ctrlState_t ctrlState;
    keyIdx_t    roundCnt;
    aesBlock_t  stateReg;

    // --------------------
    // FSM, counter and state register
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            ctrlState <= IDLE;
            roundCnt  <= '0;
            stateReg  <= '0;
        end
        else
        begin
            case (ctrlState)
                IDLE:
                begin
                    if (req)
                    begin
                        stateReg  <= cipherText ^ rdKey;   // key 10 addRoundKey
                        roundCnt  <= keyIdx_t'(`AES_NR - 1);
                        ctrlState <= ROUND;
                    end
                end
                ROUND:
                begin
                    stateReg <= round.nextState;
                    if (roundCnt == '0)
                        ctrlState <= DONE;
                    else
                        roundCnt <= roundCnt - keyIdx_t'(1);
                end
                DONE:
                begin
                    // hold result until requester lets go
                    if (!req)
                        ctrlState <= IDLE;
                end
                default:
                begin
                    ctrlState <= IDLE;
                end
            endcase
        end
    end

    // key 10 is ready for the next start
    assign rdIdx = (ctrlState == ROUND) ? roundCnt : keyIdx_t'(`AES_NR);

    assign round.roundState = stateReg;
    assign round.roundKey   = rdKey;
    assign round.lastRound  = (roundCnt == '0);

    assign ack       = (ctrlState == DONE);
    assign plainText = stateReg;

    // --------------------
    // checks
    roundCntInRange: assert property (
        @(posedge clk) disable iff (!arstN)
        roundCnt <= keyIdx_t'(`AES_NR)
    ) else $error("round counter %0d past last round", roundCnt);

    // requester must still hold req when the result appears
    ackRiseWithReq: assert property (
        @(posedge clk) disable iff (!arstN)
        $rose(ack) |-> $past(req)
    ) else $error("ack rose without a pending req");

    ackFallAfterReq: assert property (
        @(posedge clk) disable iff (!arstN)
        $fell(ack) |-> !$past(req)
    ) else $error("ack dropped while req still high");

endmodule

`default_nettype wire

// ==== design/invMixColumn.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_params.svh"

module invMixColumn import aesInvPkg::*;
(
    input  aesWord_t colIn,
    output aesWord_t colOut
);
    localparam int ROWS = `AES_WORD_BITS / `AES_BYTE_BITS;

    // first row of the circulant matrix
    localparam aesByte_t INV_MIX_ROW [ROWS] = '{8'h0e, 8'h0b, 8'h0d, 8'h09};

    always_comb
    begin
        aesByte_t acc;
        for (int r = 0; r < ROWS; r++)
        begin
            acc = '0;
            for (int c = 0; c < ROWS; c++)
            begin
                // row r is row 0 rotated right by r
                acc = acc ^ gfMul(INV_MIX_ROW[(c - r + ROWS) % ROWS],
                                  colIn[(ROWS - 1 - c) * `AES_BYTE_BITS +: `AES_BYTE_BITS]);
            end
            colOut[(ROWS - 1 - r) * `AES_BYTE_BITS +: `AES_BYTE_BITS] = acc;
        end
    end

endmodule

`default_nettype wire

// ==== design/invRoundIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// one inverse round, state in and state out
interface invRoundIf import aesInvPkg::*;
();
    aesBlock_t roundState;
    aesBlock_t roundKey;
    logic      lastRound;    // skip InvMixColumns
    aesBlock_t nextState;

    modport ctrl
    (
        output roundState,
        output roundKey,
        output lastRound,
        input  nextState
    );

    modport unit
    (
        input  roundState,
        input  roundKey,
        input  lastRound,
        output nextState
    );
endinterface

`default_nettype wire

// ==== design/invRoundUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_params.svh"

module invRoundUnit import aesInvPkg::*;
(
    invRoundIf.unit round
);
    localparam int ROWS = `AES_WORD_BITS / `AES_BYTE_BITS;

    aesBlock_t subState;
    aesBlock_t keyedState;
    aesBlock_t mixedState;

    // --------------------
    // InvShiftRows + InvSubBytes
    always_comb
    begin
        int dst;
        int src;
        for (int c = 0; c < `AES_NB; c++)
        begin
            for (int r = 0; r < ROWS; r++)
            begin
                // byte r+4c sits at the msb end first
                dst = `AES_BLOCK_BITS - `AES_BYTE_BITS * (r + ROWS * c + 1);
                src = `AES_BLOCK_BITS
                    - `AES_BYTE_BITS * (r + ROWS * ((c - r + `AES_NB) % `AES_NB) + 1);
                subState[dst +: `AES_BYTE_BITS] =
                    invSubByte(round.roundState[src +: `AES_BYTE_BITS]);
            end
        end
    end

    assign keyedState = subState ^ round.roundKey;

    // --------------------
    // InvMixColumns per column
    genvar col;
    generate
        for (col = 0; col < `AES_NB; col++)
        begin : gMix
            invMixColumn invMixColumn_inst
            (
                .colIn  (keyedState[`AES_BLOCK_BITS - `AES_WORD_BITS * (col + 1) +: `AES_WORD_BITS]),
                .colOut (mixedState[`AES_BLOCK_BITS - `AES_WORD_BITS * (col + 1) +: `AES_WORD_BITS])
            );
        end
    endgenerate

    assign round.nextState = round.lastRound ? keyedState : mixedState;   // last round has no mix

endmodule

`default_nettype wire

// ==== design/roundKeyStore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_params.svh"

module roundKeyStore import aesInvPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      keyWe,
    input  keyIdx_t   keyIdx,
    input  aesBlock_t keyData,
    input  keyIdx_t   rdIdx,
    output aesBlock_t rdKey
);
    aesBlock_t keyMem [`AES_NR + 1];

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i <= `AES_NR; i++)
                keyMem[i] <= '0;
        end
        else if (keyWe && (keyIdx <= keyIdx_t'(`AES_NR)))
        begin
            keyMem[keyIdx] <= keyData;
        end
    end

    // async read
    assign rdKey = keyMem[rdIdx];

    // --------------------
    // loader must stay inside the schedule
    keyIdxInRange: assert property (
        @(posedge clk) disable iff (!arstN)
        keyWe |-> (keyIdx <= keyIdx_t'(`AES_NR))
    ) else $error("round key write index %0d beyond last round", keyIdx);

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
design/aesInvPkg.sv
design/invRoundIf.sv
design/invMixColumn.sv
design/invRoundUnit.sv
design/roundKeyStore.sv
design/invCipherCtrl.sv
design/aesDecrypt.sv
bench/aesDecryptTb.sv
